// File: common/dmacRegPkg.sv
package dmacRegPkg;

	// Word offsets inside a channel's four-word block
	localparam logic [1:0] SAR_OFS = 2'd0;
	localparam logic [1:0] DAR_OFS = 2'd1;
	localparam logic [1:0] TCR_OFS = 2'd2;
	localparam logic [1:0] CHCR_OFS = 2'd3;

	// Operation register sits above the channel blocks
	localparam logic [4:0] DMAOR_WORD = 5'd16;

	localparam int TCR_W = 16;

	typedef struct packed {
		logic [6:0] rsvd;
		logic rs;
		logic [1:0] sm;
		logic [1:0] dm;
		logic ts;
		logic ie;
		logic te;
		logic de;
	} chcrFields_t;

	typedef union packed {
		chcrFields_t f;
		logic [15:0] raw;
	} chcrWord_u;

	// te only clears through a write, so it is outside the write mask
	localparam logic [15:0] CHCR_WMASK = 16'h01FD;
	localparam logic [15:0] CHCR_RMASK = 16'h01FF;

endpackage

// File: common/dmacBusPkg.sv
package dmacBusPkg;

	localparam int DATA_W = 32;
	localparam int SEL_W = 4;

	// Transfer size, the ts bit
	localparam logic SIZE_BYTE = 1'b0;
	localparam logic SIZE_HALF = 1'b1;

	// Address modes, code 3 behaves as fixed
	localparam logic [1:0] MODE_FIXED = 2'd0;
	localparam logic [1:0] MODE_INC = 2'd1;
	localparam logic [1:0] MODE_DEC = 2'd2;

endpackage

// File: design/dmacArbiter.sv
`timescale 1ns/10ps

module dmacArbiter #(
	parameter int NUM_CH = 2,
	localparam int CH_W = (NUM_CH > 1) ? $clog2(NUM_CH) : 1
) (
	input  logic CLK,
	input  logic RST_N,
	input  logic [NUM_CH-1:0] chEnable,
	input  logic [NUM_CH-1:0] chAuto,
	input  logic [NUM_CH-1:0] dreqN,
	input  logic busy,
	output logic grant,
	output logic [CH_W-1:0] grantCh
);

	logic [NUM_CH-1:0] req;
	logic pickValid;
	logic [CH_W-1:0] pickCh;
	logic grantNow;

	assign req = chEnable & (chAuto | ~dreqN);

	// grantCh holds the last served channel, which only wins when alone
	always_comb begin
		pickValid = 1'b0;
		pickCh = grantCh;
		for (int ch = NUM_CH - 1; ch >= 0; ch--) begin
			if (req[ch] && CH_W'(ch) != grantCh) begin
				pickValid = 1'b1;
				pickCh = CH_W'(ch);
			end
		end
		if (!pickValid && req[grantCh])
			pickValid = 1'b1;
	end

	// busy is still low in the grant cycle itself
	assign grantNow = pickValid && !busy && !grant;

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			grant <= 1'b0;
			grantCh <= '0;
		end else begin
			grant <= grantNow;
			if (grantNow)
				grantCh <= pickCh;
		end
	end

endmodule

// File: channel/dmacChannelRegs.sv
`timescale 1ns/10ps

module dmacChannelRegs
	import dmacRegPkg::*;
	import dmacBusPkg::*;
#(
	parameter int NUM_CH = 2,
	parameter int ADDR_W = 28,
	localparam int CH_W = (NUM_CH > 1) ? $clog2(NUM_CH) : 1
) (
	input  logic CLK,
	input  logic RST_N,
	input  logic regCyc,
	input  logic regStb,
	input  logic regWe,
	input  logic [4:0] regAdr,
	input  logic [DATA_W-1:0] regDatW,
	input  logic [CH_W-1:0] activeCh,
	input  logic srcStep,
	input  logic dstStep,
	output logic [DATA_W-1:0] regDatR,
	output logic regAck,
	output logic [ADDR_W-1:0] curSar,
	output logic [ADDR_W-1:0] curDar,
	output logic curTs,
	output logic [NUM_CH-1:0] chEnable,
	output logic [NUM_CH-1:0] chAuto,
	output logic [NUM_CH-1:0] irq
);

	logic [ADDR_W-1:0] sar [NUM_CH];
	logic [ADDR_W-1:0] dar [NUM_CH];
	logic [TCR_W-1:0] tcr [NUM_CH];
	chcrWord_u chcr [NUM_CH];
	chcrWord_u chcrWr [NUM_CH];
	logic dme;

	logic regReq;
	logic regWr;
	logic chSpace;
	logic [1:0] regCh;
	logic [1:0] regOfs;
	logic [DATA_W-1:0] rdWord;

	function automatic logic [ADDR_W-1:0] stepAddr(input logic [ADDR_W-1:0] addr,
			input logic [1:0] mode, input logic ts);
		logic [ADDR_W-1:0] size;
		size = (ts == SIZE_HALF) ? ADDR_W'(2) : ADDR_W'(1);
		case (mode)
			MODE_FIXED: return addr;
			MODE_INC: return addr + size;
			MODE_DEC: return addr - size;
			default: return addr;
		endcase
	endfunction

	// One request per strobe, acknowledged on the following cycle
	assign regReq = regCyc && regStb && !regAck;
	assign regWr = regReq && regWe;
	assign chSpace = !regAdr[4];
	assign regCh = regAdr[3:2];
	assign regOfs = regAdr[1:0];

	// Written te can only keep or clear the current flag
	always_comb begin
		for (int ch = 0; ch < NUM_CH; ch++) begin
			chcrWr[ch].raw = regDatW[15:0] & CHCR_WMASK;
			chcrWr[ch].f.te = chcr[ch].f.te & regDatW[1];
		end
	end

	always_ff @(posedge CLK) begin
		for (int ch = 0; ch < NUM_CH; ch++) begin
			if (regWr && chSpace && regCh == 2'(ch) && regOfs == SAR_OFS)
				sar[ch] <= regDatW[ADDR_W-1:0];
			else if (srcStep && activeCh == CH_W'(ch))
				sar[ch] <= stepAddr(sar[ch], chcr[ch].f.sm, chcr[ch].f.ts);

			if (regWr && chSpace && regCh == 2'(ch) && regOfs == DAR_OFS)
				dar[ch] <= regDatW[ADDR_W-1:0];
			else if (dstStep && activeCh == CH_W'(ch))
				dar[ch] <= stepAddr(dar[ch], chcr[ch].f.dm, chcr[ch].f.ts);

			if (regWr && chSpace && regCh == 2'(ch) && regOfs == TCR_OFS)
				tcr[ch] <= regDatW[TCR_W-1:0];
			else if (dstStep && activeCh == CH_W'(ch))
				tcr[ch] <= tcr[ch] - TCR_W'(1);
		end

		if (regReq && !regWe)
			regDatR <= rdWord;
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			for (int ch = 0; ch < NUM_CH; ch++) begin
				chcr[ch].raw <= '0;
			end
			dme <= 1'b0;
			regAck <= 1'b0;
		end else begin
			regAck <= regReq;
			if (regWr && regAdr == DMAOR_WORD)
				dme <= regDatW[0];
			for (int ch = 0; ch < NUM_CH; ch++) begin
				if (regWr && chSpace && regCh == 2'(ch) && regOfs == CHCR_OFS)
					chcr[ch] <= chcrWr[ch];
				else if (dstStep && activeCh == CH_W'(ch) && tcr[ch] == TCR_W'(1))
					chcr[ch].f.te <= 1'b1;
			end
		end
	end

	always_comb begin
		rdWord = '0;
		if (regAdr == DMAOR_WORD)
			rdWord[0] = dme;
		for (int ch = 0; ch < NUM_CH; ch++) begin
			if (chSpace && regCh == 2'(ch)) begin
				case (regOfs)
					SAR_OFS: rdWord = DATA_W'(sar[ch]);
					DAR_OFS: rdWord = DATA_W'(dar[ch]);
					TCR_OFS: rdWord = DATA_W'(tcr[ch]);
					CHCR_OFS: rdWord = DATA_W'(chcr[ch].raw & CHCR_RMASK);
					default: rdWord = '0;
				endcase
			end
		end
	end

	assign curSar = sar[activeCh];
	assign curDar = dar[activeCh];
	assign curTs = chcr[activeCh].f.ts;

	always_comb begin
		for (int ch = 0; ch < NUM_CH; ch++) begin
			chEnable[ch] = dme && chcr[ch].f.de && !chcr[ch].f.te;
			chAuto[ch] = chcr[ch].f.rs;
			irq[ch] = chcr[ch].f.te && chcr[ch].f.ie;
		end
	end

endmodule

// File: transfer/dmacTransfer.sv
`timescale 1ns/10ps

module dmacTransfer
	import dmacBusPkg::*;
#(
	parameter int NUM_CH = 2,
	parameter int ADDR_W = 28,
	localparam int CH_W = (NUM_CH > 1) ? $clog2(NUM_CH) : 1
) (
	input  logic CLK,
	input  logic RST_N,
	input  logic grant,
	input  logic [CH_W-1:0] grantCh,
	input  logic [ADDR_W-1:0] curSar,
	input  logic [ADDR_W-1:0] curDar,
	input  logic curTs,
	input  logic [DATA_W-1:0] memDatR,
	input  logic memAck,
	output logic busy,
	output logic [CH_W-1:0] activeCh,
	output logic srcStep,
	output logic dstStep,
	output logic memCyc,
	output logic memStb,
	output logic memWe,
	output logic [ADDR_W-1:0] memAdr,
	output logic [SEL_W-1:0] memSel,
	output logic [DATA_W-1:0] memDatW
);

	localparam logic [1:0] ST_IDLE = 2'd0;
	localparam logic [1:0] ST_READ = 2'd1;
	localparam logic [1:0] ST_WRITE = 2'd2;

	logic [1:0] state;
	logic [DATA_W-1:0] wrData;

	// Lanes are big-endian, byte address 0 lives in bits 31:24
	function automatic logic [SEL_W-1:0] laneSel(input logic [1:0] addr, input logic ts);
		if (ts == SIZE_BYTE)
			return SEL_W'(4'b1000 >> addr);
		return addr[1] ? SEL_W'(4'b0011) : SEL_W'(4'b1100);
	endfunction

	// Pick the source unit and copy it onto every lane
	function automatic logic [DATA_W-1:0] spread(input logic [DATA_W-1:0] data,
			input logic [1:0] addr, input logic ts);
		logic [7:0] unitB;
		logic [15:0] unitH;
		case (addr)
			2'd0: unitB = data[31:24];
			2'd1: unitB = data[23:16];
			2'd2: unitB = data[15:8];
			default: unitB = data[7:0];
		endcase
		unitH = addr[1] ? data[15:0] : data[31:16];
		return (ts == SIZE_BYTE) ? {4{unitB}} : {2{unitH}};
	endfunction

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			state <= ST_IDLE;
			activeCh <= '0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (grant) begin
						state <= ST_READ;
						activeCh <= grantCh;
					end
				end
				ST_READ: begin
					if (memAck)
						state <= ST_WRITE;
				end
				ST_WRITE: begin
					if (memAck)
						state <= ST_IDLE;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// Source low bits are sampled before SAR steps at this edge
	always_ff @(posedge CLK) begin
		if (state == ST_READ && memAck)
			wrData <= spread(memDatR, curSar[1:0], curTs);
	end

	assign busy = state != ST_IDLE;
	assign memCyc = busy;
	assign memStb = busy;
	assign memWe = state == ST_WRITE;
	assign memAdr = memWe ? curDar : curSar;
	assign memSel = laneSel(memAdr[1:0], curTs);
	assign memDatW = wrData;

	assign srcStep = state == ST_READ && memAck;
	assign dstStep = state == ST_WRITE && memAck;

endmodule

// File: design/dmacTop.sv
`timescale 1ns/10ps

module dmacTop
	import dmacBusPkg::*;
#(
	parameter int NUM_CH = 2,
	parameter int ADDR_W = 28,
	localparam int CH_W = (NUM_CH > 1) ? $clog2(NUM_CH) : 1
) (
	input  logic CLK,
	input  logic RST_N,

	input  logic regCyc,
	input  logic regStb,
	input  logic regWe,
	input  logic [4:0] regAdr,
	input  logic [DATA_W-1:0] regDatW,
	output logic [DATA_W-1:0] regDatR,
	output logic regAck,

	output logic memCyc,
	output logic memStb,
	output logic memWe,
	output logic [ADDR_W-1:0] memAdr,
	output logic [SEL_W-1:0] memSel,
	output logic [DATA_W-1:0] memDatW,
	input  logic [DATA_W-1:0] memDatR,
	input  logic memAck,

	input  logic [NUM_CH-1:0] dreqN,
	output logic [NUM_CH-1:0] irq
);

	logic [NUM_CH-1:0] chEnable;
	logic [NUM_CH-1:0] chAuto;
	logic grant;
	logic [CH_W-1:0] grantCh;
	logic busy;
	logic [CH_W-1:0] activeCh;
	logic srcStep;
	logic dstStep;
	logic [ADDR_W-1:0] curSar;
	logic [ADDR_W-1:0] curDar;
	logic curTs;

	dmacChannelRegs #(
		.NUM_CH(NUM_CH),
		.ADDR_W(ADDR_W)
	) regs_i (
		.CLK(CLK),
		.RST_N(RST_N),
		.regCyc(regCyc),
		.regStb(regStb),
		.regWe(regWe),
		.regAdr(regAdr),
		.regDatW(regDatW),
		.activeCh(activeCh),
		.srcStep(srcStep),
		.dstStep(dstStep),
		.regDatR(regDatR),
		.regAck(regAck),
		.curSar(curSar),
		.curDar(curDar),
		.curTs(curTs),
		.chEnable(chEnable),
		.chAuto(chAuto),
		.irq(irq)
	);

	dmacArbiter #(
		.NUM_CH(NUM_CH)
	) arb_i (
		.CLK(CLK),
		.RST_N(RST_N),
		.chEnable(chEnable),
		.chAuto(chAuto),
		.dreqN(dreqN),
		.busy(busy),
		.grant(grant),
		.grantCh(grantCh)
	);

	dmacTransfer #(
		.NUM_CH(NUM_CH),
		.ADDR_W(ADDR_W)
	) xfer_i (
		.CLK(CLK),
		.RST_N(RST_N),
		.grant(grant),
		.grantCh(grantCh),
		.curSar(curSar),
		.curDar(curDar),
		.curTs(curTs),
		.memDatR(memDatR),
		.memAck(memAck),
		.busy(busy),
		.activeCh(activeCh),
		.srcStep(srcStep),
		.dstStep(dstStep),
		.memCyc(memCyc),
		.memStb(memStb),
		.memWe(memWe),
		.memAdr(memAdr),
		.memSel(memSel),
		.memDatW(memDatW)
	);

endmodule

// File: bench/dmacClockGen.sv
`timescale 1ns/10ps

module dmacClockGen #(
	parameter int PERIOD = 40,
	parameter int RST_CYCLES = 4
) (
	output logic CLK,
	output logic RST_N
);

	initial begin
		CLK = 1'b0;
		forever #(PERIOD / 2) CLK = ~CLK;
	end

	// Release just after the last reset edge
	initial begin
		RST_N = 1'b0;
		repeat (RST_CYCLES) @(posedge CLK);
		#1 RST_N = 1'b1;
	end

endmodule

// File: bench/dmacMemModel.sv
`timescale 1ns/10ps

module dmacMemModel
	import dmacBusPkg::*;
#(
	parameter int ADDR_W = 28
) (
	input  logic CLK,
	input  logic RST_N,
	input  logic memCyc,
	input  logic memStb,
	input  logic memWe,
	input  logic [ADDR_W-1:0] memAdr,
	input  logic [SEL_W-1:0] memSel,
	input  logic [DATA_W-1:0] memDatW,
	output logic [DATA_W-1:0] memDatR,
	output logic memAck
);

	localparam int MEM_SIZE = 4096;

	logic [7:0] mem [MEM_SIZE];
	logic [1:0] delay;
	logic [11:0] base;

	// Fill value mixes every address bit
	function automatic logic [7:0] fillByte(input logic [11:0] a);
		return a[7:0] ^ {a[11:8], a[11:8]} ^ 8'h5A;
	endfunction

	// Big-endian lanes, byte 0 of a word sits in bits 31:24
	assign base = {memAdr[11:2], 2'b00};

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			for (int a = 0; a < MEM_SIZE; a++) begin
				mem[12'(a)] <= fillByte(12'(a));
			end
			delay <= 2'd0;
			memAck <= 1'b0;
			memDatR <= '0;
		end else begin
			memAck <= 1'b0;
			if (memCyc && memStb && !memAck) begin
				if (delay == 2'd0) begin
					memAck <= 1'b1;
					delay <= 2'($urandom % 4);
					if (memWe) begin
						for (int i = 0; i < SEL_W; i++) begin
							if (memSel[SEL_W-1-i])
								mem[base + 12'(i)] <= memDatW[DATA_W-1-8*i -: 8];
						end
					end else begin
						memDatR <= {mem[base], mem[base + 12'd1], mem[base + 12'd2],
							mem[base + 12'd3]};
					end
				end else begin
					delay <= delay - 2'd1;
				end
			end
		end
	end

endmodule

// File: bench/dmacTb.sv
`timescale 1ns/10ps

module dmacTb
	import dmacRegPkg::*;
	import dmacBusPkg::*;
();

	localparam int NUM_CH = 2;
	localparam int ADDR_W = 28;

	logic CLK;
	logic RST_N;
	logic regCyc;
	logic regStb;
	logic regWe;
	logic [4:0] regAdr;
	logic [DATA_W-1:0] regDatW;
	logic [DATA_W-1:0] regDatR;
	logic regAck;
	logic memCyc;
	logic memStb;
	logic memWe;
	logic [ADDR_W-1:0] memAdr;
	logic [SEL_W-1:0] memSel;
	logic [DATA_W-1:0] memDatW;
	logic [DATA_W-1:0] memDatR;
	logic memAck;
	logic [NUM_CH-1:0] dreqN;
	logic [NUM_CH-1:0] irq;

	int errCount = 0;
	int errAtStart = 0;
	int testsRun = 0;
	int testsFailed = 0;

	logic logReads = 1'b0;
	logic [ADDR_W-1:0] readLog [$];

	dmacClockGen #(.PERIOD(40), .RST_CYCLES(4)) clk_i (.CLK(CLK), .RST_N(RST_N));

	dmacMemModel #(.ADDR_W(ADDR_W)) mem_i (
		.CLK(CLK), .RST_N(RST_N), .memCyc(memCyc), .memStb(memStb), .memWe(memWe),
		.memAdr(memAdr), .memSel(memSel), .memDatW(memDatW), .memDatR(memDatR),
		.memAck(memAck)
	);

	dmacTop #(.NUM_CH(NUM_CH), .ADDR_W(ADDR_W)) dut_i (
		.CLK(CLK), .RST_N(RST_N),
		.regCyc(regCyc), .regStb(regStb), .regWe(regWe), .regAdr(regAdr),
		.regDatW(regDatW), .regDatR(regDatR), .regAck(regAck),
		.memCyc(memCyc), .memStb(memStb), .memWe(memWe), .memAdr(memAdr),
		.memSel(memSel), .memDatW(memDatW), .memDatR(memDatR), .memAck(memAck),
		.dreqN(dreqN), .irq(irq)
	);

	// Source address of each acknowledged read
	always @(negedge CLK) begin
		if (logReads && memCyc && memAck && !memWe)
			readLog.push_back(memAdr);
	end

	// Same fill rule as the memory model
	function automatic logic [7:0] patternByte(input logic [11:0] a);
		return a[7:0] ^ {a[11:8], a[11:8]} ^ 8'h5A;
	endfunction

	function automatic logic [4:0] chWord(input logic [0:0] ch, input logic [1:0] ofs);
		return {2'b00, ch, ofs};
	endfunction

	function automatic chcrWord_u makeChcr(input logic de, input logic ie, input logic ts,
			input logic [1:0] dm, input logic [1:0] sm, input logic rs);
		chcrWord_u w;
		w.raw = '0;
		w.f.de = de;
		w.f.ie = ie;
		w.f.ts = ts;
		w.f.dm = dm;
		w.f.sm = sm;
		w.f.rs = rs;
		return w;
	endfunction

	task automatic checkAddr(input string name, input logic [ADDR_W-1:0] exp,
			input logic [ADDR_W-1:0] act);
		if (act !== exp) begin
			$display("mismatch %s: expected %h, got %h", name, exp, act);
			errCount++;
		end
	endtask

	task automatic checkData(input string name, input logic [DATA_W-1:0] exp,
			input logic [DATA_W-1:0] act);
		if (act !== exp) begin
			$display("mismatch %s: expected %h, got %h", name, exp, act);
			errCount++;
		end
	endtask

	task automatic checkChcr(input string name, input chcrWord_u exp, input chcrWord_u act);
		if (act.raw !== exp.raw) begin
			$display("mismatch %s: expected %h, got %h", name, exp.raw, act.raw);
			errCount++;
		end
	endtask

	// One Wishbone classic access, started 1 ns after an edge
	task automatic slaveCycle(input logic we, input logic [4:0] adr,
			input logic [DATA_W-1:0] wdata, output logic [DATA_W-1:0] rdata);
		int cycles;
		@(posedge CLK);
		#1;
		regCyc = 1'b1;
		regStb = 1'b1;
		regWe = we;
		regAdr = adr;
		regDatW = wdata;
		cycles = 0;
		do begin
			@(posedge CLK);
			#1;
			cycles++;
		end while (!regAck && cycles < 20);
		if (!regAck) begin
			$display("error: register access to word %0d was never acknowledged", adr);
			errCount++;
		end
		rdata = regDatR;
		regCyc = 1'b0;
		regStb = 1'b0;
		regWe = 1'b0;
	endtask

	task automatic regWrite(input logic [4:0] adr, input logic [DATA_W-1:0] data);
		logic [DATA_W-1:0] unused;
		slaveCycle(1'b1, adr, data, unused);
	endtask

	task automatic regRead(input logic [4:0] adr, output logic [DATA_W-1:0] data);
		slaveCycle(1'b0, adr, '0, data);
	endtask

	task automatic waitIrq(input logic [0:0] ch);
		int cycles;
		cycles = 0;
		while (!irq[ch] && cycles < 400) begin
			@(posedge CLK);
			#1;
			cycles++;
		end
		if (!irq[ch]) begin
			$display("error: irq[%0d] did not rise within %0d cycles", ch, cycles);
			errCount++;
		end
	endtask

	task automatic watchBusIdle(input int cycles, input string what);
		logic seen;
		seen = 1'b0;
		for (int i = 0; i < cycles; i++) begin
			@(posedge CLK);
			#1;
			if (memCyc || memStb)
				seen = 1'b1;
		end
		if (seen) begin
			$display("error: a bus cycle started %s", what);
			errCount++;
		end
	endtask

	task automatic setupChannel(input logic [0:0] ch, input int unsigned src,
			input int unsigned dst, input int unsigned count, input chcrWord_u ctl);
		regWrite(chWord(ch, SAR_OFS), 32'(src));
		regWrite(chWord(ch, DAR_OFS), 32'(dst));
		regWrite(chWord(ch, TCR_OFS), 32'(count));
		regWrite(chWord(ch, CHCR_OFS), 32'(ctl.raw));
	endtask

	// Final address, count and flag state of a finished channel
	task automatic checkEnd(input logic [0:0] ch, input int unsigned sar,
			input int unsigned dar, input chcrWord_u ctl);
		logic [DATA_W-1:0] rd;
		chcrWord_u act;
		regRead(chWord(ch, SAR_OFS), rd);
		checkAddr("SAR", ADDR_W'(sar), rd[ADDR_W-1:0]);
		regRead(chWord(ch, DAR_OFS), rd);
		checkAddr("DAR", ADDR_W'(dar), rd[ADDR_W-1:0]);
		regRead(chWord(ch, TCR_OFS), rd);
		checkData("TCR", 32'd0, rd);
		regRead(chWord(ch, CHCR_OFS), rd);
		act.raw = rd[15:0];
		ctl.f.te = 1'b1;
		checkChcr("CHCR", ctl, act);
	endtask

	task automatic checkCopy(input int unsigned src, input int unsigned dst, input int bytes,
			input logic dstDown);
		int unsigned d;
		for (int k = 0; k < bytes; k++) begin
			d = dstDown ? dst - k : dst + k;
			checkData($sformatf("mem[%h]", d), 32'(patternByte(12'(src + k))),
				32'(mem_i.mem[12'(d)]));
		end
	endtask

	// While both channels have units left, neither is served twice in a row
	task automatic checkAlternation(input logic [ADDR_W-1:0] base1, input int units0,
			input int units1);
		int remaining [2];
		logic ch;
		logic prevCh;
		if (readLog.size() != units0 + units1) begin
			$display("error: %0d reads seen, expected %0d", readLog.size(), units0 + units1);
			errCount++;
		end
		remaining[0] = units0;
		remaining[1] = units1;
		prevCh = 1'b0;
		foreach (readLog[i]) begin
			ch = readLog[i] >= base1;
			if (i > 0 && ch == prevCh && remaining[!ch] > 0) begin
				$display("error: channel %0d was served twice in a row while the other waited",
					ch);
				errCount++;
			end
			remaining[ch]--;
			prevCh = ch;
		end
	endtask

	task automatic finishTest(input string name);
		testsRun++;
		if (errCount != errAtStart) begin
			testsFailed++;
			$display("test %s: failed", name);
		end else begin
			$display("test %s: ok", name);
		end
		errAtStart = errCount;
	endtask

	task automatic maskedRegs();
		logic [DATA_W-1:0] rd;
		chcrWord_u act;
		checkData("memCyc after reset", 32'd0, 32'(memCyc));
		checkData("memStb after reset", 32'd0, 32'(memStb));
		checkData("regAck after reset", 32'd0, 32'(regAck));
		checkData("irq after reset", 32'd0, 32'(irq));
		regWrite(chWord(0, SAR_OFS), 32'h0ABCDEF1);
		regWrite(chWord(1, DAR_OFS), 32'h0123456E);
		regWrite(chWord(0, TCR_OFS), 32'hDEAD1234);
		regWrite(chWord(1, CHCR_OFS), 32'hABCDFFFE);
		regRead(chWord(0, SAR_OFS), rd);
		checkAddr("SAR0", 28'hABCDEF1, rd[ADDR_W-1:0]);
		regRead(chWord(1, DAR_OFS), rd);
		checkAddr("DAR1", 28'h123456E, rd[ADDR_W-1:0]);
		regRead(chWord(0, TCR_OFS), rd);
		checkData("TCR0", 32'h00001234, rd);
		// Reserved bits and te stay zero
		regRead(chWord(1, CHCR_OFS), rd);
		act.raw = rd[15:0];
		checkChcr("CHCR1", makeChcr(1'b0, 1'b1, 1'b1, 2'd3, 2'd3, 1'b1), act);
		checkData("CHCR1 upper", 32'd0, {rd[31:16], 16'd0});
		regWrite(chWord(1, CHCR_OFS), 32'd0);
		finishTest("register access");
	endtask

	task automatic halfCopy();
		chcrWord_u ctl;
		ctl = makeChcr(1'b1, 1'b1, SIZE_HALF, MODE_INC, MODE_INC, 1'b1);
		regWrite(DMAOR_WORD, 32'd1);
		setupChannel(0, 'h100, 'h800, 4, ctl);
		waitIrq(0);
		checkCopy('h100, 'h800, 8, 1'b0);
		checkEnd(0, 'h108, 'h808, ctl);
		checkData("irq", 32'd1, 32'(irq));
		finishTest("halfword copy");
	endtask

	task automatic byteMixedModes();
		chcrWord_u ctl;
		ctl = makeChcr(1'b1, 1'b1, SIZE_BYTE, MODE_DEC, MODE_INC, 1'b1);
		setupChannel(0, 'h205, 'h90B, 3, ctl);
		waitIrq(0);
		checkCopy('h205, 'h90B, 3, 1'b1);
		checkEnd(0, 'h208, 'h908, ctl);
		finishTest("byte copy mixed modes");
	endtask

	task automatic externalRequest();
		chcrWord_u ctl;
		logic [DATA_W-1:0] rd;
		ctl = makeChcr(1'b1, 1'b1, SIZE_HALF, MODE_INC, MODE_INC, 1'b0);
		setupChannel(1, 'h300, 'hA00, 2, ctl);
		watchBusIdle(50, "with dreqN high");
		regRead(chWord(1, TCR_OFS), rd);
		checkData("TCR1 before request", 32'd2, rd);
		dreqN[1] = 1'b0;
		waitIrq(1);
		dreqN[1] = 1'b1;
		checkCopy('h300, 'hA00, 4, 1'b0);
		checkEnd(1, 'h304, 'hA04, ctl);
		finishTest("external request");
	endtask

	task automatic twoChannels();
		chcrWord_u ctl0;
		chcrWord_u ctl1;
		ctl0 = makeChcr(1'b1, 1'b1, SIZE_HALF, MODE_INC, MODE_INC, 1'b1);
		ctl1 = makeChcr(1'b1, 1'b1, SIZE_BYTE, MODE_INC, MODE_INC, 1'b1);
		readLog.delete();
		logReads = 1'b1;
		regWrite(chWord(1, SAR_OFS), 32'h500);
		regWrite(chWord(1, DAR_OFS), 32'hC00);
		regWrite(chWord(1, TCR_OFS), 32'd4);
		setupChannel(0, 'h400, 'hB00, 3, ctl0);
		regWrite(chWord(1, CHCR_OFS), 32'(ctl1.raw));
		waitIrq(0);
		waitIrq(1);
		logReads = 1'b0;
		checkAlternation(28'h500, 3, 4);
		checkCopy('h400, 'hB00, 6, 1'b0);
		checkCopy('h500, 'hC00, 4, 1'b0);
		checkEnd(0, 'h406, 'hB06, ctl0);
		checkEnd(1, 'h504, 'hC04, ctl1);
		checkData("irq", 32'd3, 32'(irq));
		finishTest("two channels");
	endtask

	task automatic controlBits();
		chcrWord_u ctl;
		chcrWord_u act;
		logic [DATA_W-1:0] rd;
		ctl = makeChcr(1'b0, 1'b1, SIZE_HALF, MODE_INC, MODE_INC, 1'b1);
		regWrite(chWord(0, CHCR_OFS), 32'(ctl.raw));
		checkData("irq0 after te clear", 32'd0, 32'(irq[0]));
		regRead(chWord(0, CHCR_OFS), rd);
		act.raw = rd[15:0];
		checkChcr("CHCR0", ctl, act);
		regWrite(DMAOR_WORD, 32'd0);
		setupChannel(1, 'h600, 'hD00, 2,
			makeChcr(1'b1, 1'b1, SIZE_BYTE, MODE_INC, MODE_INC, 1'b1));
		watchBusIdle(50, "with DME clear");
		regRead(chWord(1, TCR_OFS), rd);
		checkData("TCR1 with DME clear", 32'd2, rd);
		finishTest("control bits");
	endtask

	initial begin
		int cycles;
		void'($urandom(22));
		regCyc = 1'b0;
		regStb = 1'b0;
		regWe = 1'b0;
		regAdr = '0;
		regDatW = '0;
		dreqN = '1;
		cycles = 0;
		while (!RST_N && cycles < 20) begin
			@(posedge CLK);
			cycles++;
		end
		if (!RST_N) begin
			$display("error: reset was never released");
			errCount++;
		end

		maskedRegs();
		halfCopy();
		byteMixedModes();
		externalRequest();
		twoChannels();
		controlBits();

		$display("tests %0d, failed %0d, errors %0d", testsRun, testsFailed, errCount);
		if (errCount == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

// File: build.f
common/dmacRegPkg.sv
common/dmacBusPkg.sv
design/dmacArbiter.sv
channel/dmacChannelRegs.sv
transfer/dmacTransfer.sv
design/dmacTop.sv
bench/dmacClockGen.sv
bench/dmacMemModel.sv
bench/dmacTb.sv

// File: run.sh
#!/bin/sh
# Build and run the DMA controller testbench with Verilator

verilator --binary --timing -f build.f --top-module dmacTb -o dmacSim > build.log 2>&1 \
	&& ./obj_dir/dmacSim > sim.log 2>&1 \
	|| { echo "build or simulation error, see build.log and sim.log"; exit 1; }

grep -q "PASS: all tests" sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed, see sim.log"; exit 1; }
